// ==== common/proc_config.svh ====
// datapath word, register count and register index widths
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// instruction and data word
`define PROC_WORD 16

// register file size and index width
`define PROC_REGS 8
`define PROC_REG_BITS 3

`endif

// ==== common/procPkg.sv ====
// opcodes, instruction formats and pipeline control encodings
`include "proc_config.svh"

package procPkg;

   // codes 13 to 15 are undefined and retire as illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LBI  = 4'h6,
      OP_LD   = 4'h7,
      OP_ST   = 4'h8,
      OP_BEQZ = 4'h9,
      OP_BNEZ = 4'hA,
      OP_J    = 4'hB,
      OP_HALT = 4'hC
   } opcode_e;

   // rd <= rs op rt
   typedef struct packed {
      opcode_e                   opcode;
      logic [`PROC_REG_BITS-1:0] rd;
      logic [`PROC_REG_BITS-1:0] rs;
      logic [`PROC_REG_BITS-1:0] rt;
      logic [2:0]                pad;
   } rForm_t;

   // ADDI, LD and ST
   typedef struct packed {
      opcode_e                   opcode;
      logic [`PROC_REG_BITS-1:0] rd;
      logic [`PROC_REG_BITS-1:0] rs;
      logic [5:0]                imm;
   } iForm_t;

   // LBI, branches and J
   typedef struct packed {
      opcode_e                   opcode;
      logic [`PROC_REG_BITS-1:0] rd;
      logic [8:0]                imm;
   } lForm_t;

   typedef union packed {
      rForm_t rForm;
      iForm_t iForm;
      lForm_t lForm;
   } instr_u;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_PASSB} aluOp_e;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_NONE} wbSrc_e;

   typedef enum logic [1:0] {FWD_RF, FWD_XM, FWD_MW} fwdSel_e;

endpackage

// ==== hdl/fetch.sv ====
// program counter and the fetch/decode register
`include "proc_config.svh"

module fetch (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  stall,
   input  logic                  redirect,
   input  logic                  haltSeen,
   input  logic [`PROC_WORD-1:0] redirectPc,
   output logic [`PROC_WORD-1:0] imemAddr,
   input  logic [`PROC_WORD-1:0] imemData,
   output logic [`PROC_WORD-1:0] instrD,
   output logic [`PROC_WORD-1:0] pcNextD,
   output logic                  validD
);

   logic [`PROC_WORD-1:0] pc;
   logic [`PROC_WORD-1:0] pcNext;

   assign pcNext   = pc + `PROC_WORD'd1;
   assign imemAddr = pc;

   // redirect beats stall, and a halt only starves decode of new work
   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         validD <= 1'b0;
      end else if (redirect) begin
         pc     <= redirectPc;
         validD <= 1'b0;
      end else if (!stall) begin
         if (haltSeen) begin
            validD <= 1'b0;
         end else begin
            pc     <= pcNext;
            validD <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         instrD  <= imemData;
         pcNextD <= pcNext;
      end
   end

endmodule

// ==== decode/regFile.sv ====
// eight-entry register file, two read ports with write bypass
`include "proc_config.svh"

module regFile (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`PROC_REG_BITS-1:0] rdAddrA,
   input  logic [`PROC_REG_BITS-1:0] rdAddrB,
   input  logic [`PROC_REG_BITS-1:0] wrAddr,
   input  logic                      wrEn,
   input  logic [`PROC_WORD-1:0]     wrData,
   output logic [`PROC_WORD-1:0]     rdDataA,
   output logic [`PROC_WORD-1:0]     rdDataB
);

   logic [`PROC_WORD-1:0] regs [`PROC_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PROC_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // writeback in the same cycle shows up on the read side
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== decode/decode.sv ====
// instruction decoder, immediate extension, register read
// and the decode/execute register
`include "proc_config.svh"

module decode
   import procPkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic [`PROC_WORD-1:0]     instrD,
   input  logic [`PROC_WORD-1:0]     pcNextD,
   input  logic                      validD,
   input  logic                      stall,
   input  logic                      flush,
   input  logic                      wbEn,
   input  logic [`PROC_REG_BITS-1:0] wbReg,
   input  logic [`PROC_WORD-1:0]     wbData,
   output logic [`PROC_REG_BITS-1:0] srcA,
   output logic [`PROC_REG_BITS-1:0] srcB,
   output logic                      haltSeen,
   output logic                      validX,
   output opcode_e                   opX,
   output aluOp_e                    aluOpX,
   output wbSrc_e                    wbSrcX,
   output logic                      memWrX,
   output logic                      memRdX,
   output logic [`PROC_REG_BITS-1:0] destX,
   output logic                      regWrX,
   output logic [`PROC_WORD-1:0]     opAX,
   output logic [`PROC_WORD-1:0]     opBX,
   output logic [`PROC_WORD-1:0]     storeDataX,
   output logic [`PROC_WORD-1:0]     immX,
   output logic [`PROC_WORD-1:0]     pcNextX,
   output logic [`PROC_REG_BITS-1:0] srcAX,
   output logic [`PROC_REG_BITS-1:0] srcBX,
   output logic                      illegalX
);

   instr_u                instr;
   opcode_e               op;
   aluOp_e                aluOp;
   wbSrc_e                wbSrc;
   logic                  memWr;
   logic                  memRd;
   logic                  useImm;
   logic                  longImm;
   logic                  aFromRd;
   logic                  bFromRd;
   logic                  illegal;
   logic                  haltReg;
   logic [`PROC_WORD-1:0] imm;
   logic [`PROC_WORD-1:0] rdDataA;
   logic [`PROC_WORD-1:0] rdDataB;

   assign instr = instrD;
   assign op    = instr.rForm.opcode;

   always_comb begin
      aluOp   = ALU_ADD;
      wbSrc   = WB_NONE;
      memWr   = 1'b0;
      memRd   = 1'b0;
      useImm  = 1'b0;
      longImm = 1'b0;
      aFromRd = 1'b0;
      bFromRd = 1'b0;
      illegal = 1'b0;
      case (op)
         OP_ADD: wbSrc = WB_ALU;
         OP_SUB: begin
            aluOp = ALU_SUB;
            wbSrc = WB_ALU;
         end
         OP_AND: begin
            aluOp = ALU_AND;
            wbSrc = WB_ALU;
         end
         OP_XOR: begin
            aluOp = ALU_XOR;
            wbSrc = WB_ALU;
         end
         OP_ADDI: begin
            useImm = 1'b1;
            wbSrc  = WB_ALU;
         end
         OP_LBI: begin
            aluOp   = ALU_PASSB;
            useImm  = 1'b1;
            longImm = 1'b1;
            wbSrc   = WB_ALU;
         end
         OP_LD: begin
            useImm = 1'b1;
            memRd  = 1'b1;
            wbSrc  = WB_MEM;
         end
         // store data comes from rd on the second read port
         OP_ST: begin
            useImm  = 1'b1;
            memWr   = 1'b1;
            bFromRd = 1'b1;
         end
         // branches test rd through the A operand path
         OP_BEQZ, OP_BNEZ: begin
            longImm = 1'b1;
            aFromRd = 1'b1;
         end
         OP_J: longImm = 1'b1;
         OP_NOP, OP_HALT: illegal = 1'b0;
         default: illegal = 1'b1;
      endcase
   end

   assign imm = longImm ? {{(`PROC_WORD-9){instr.lForm.imm[8]}}, instr.lForm.imm}
                        : {{(`PROC_WORD-6){instr.iForm.imm[5]}}, instr.iForm.imm};

   assign srcA = aFromRd ? instr.rForm.rd : instr.rForm.rs;
   assign srcB = bFromRd ? instr.rForm.rd : instr.rForm.rt;

   regFile regFile0 (
      .clk(clk), .rst(rst),
      .rdAddrA(srcA), .rdAddrB(srcB),
      .wrAddr(wbReg), .wrEn(wbEn), .wrData(wbData),
      .rdDataA(rdDataA), .rdDataB(rdDataB)
   );

   // a HALT on a flushed path must not freeze fetch
   assign haltSeen = haltReg | (validD && op == OP_HALT && !flush);

   always_ff @(posedge clk) begin
      if (rst) begin
         haltReg <= 1'b0;
         validX  <= 1'b0;
      end else begin
         haltReg <= haltSeen;
         validX  <= validD && !stall && !flush;
      end
   end

   // opBX already holds the immediate for the immediate forms
   always_ff @(posedge clk) begin
      opX        <= op;
      aluOpX     <= aluOp;
      wbSrcX     <= wbSrc;
      memWrX     <= memWr;
      memRdX     <= memRd;
      destX      <= instr.rForm.rd;
      regWrX     <= (wbSrc != WB_NONE);
      opAX       <= rdDataA;
      opBX       <= useImm ? imm : rdDataB;
      storeDataX <= rdDataB;
      immX       <= imm;
      pcNextX    <= pcNextD;
      srcAX      <= srcA;
      srcBX      <= srcB;
      illegalX   <= illegal;
   end

endmodule

// ==== hdl/hazard.sv ====
// load-use stall detection and operand forward selection
`include "proc_config.svh"

module hazard
   import procPkg::*;
(
   input  logic [`PROC_REG_BITS-1:0] srcA,
   input  logic [`PROC_REG_BITS-1:0] srcB,
   input  logic [`PROC_REG_BITS-1:0] srcAX,
   input  logic [`PROC_REG_BITS-1:0] srcBX,
   input  logic [`PROC_REG_BITS-1:0] destX,
   input  logic                      regWrX,
   input  logic                      memRdX,
   input  logic                      validX,
   input  logic [`PROC_REG_BITS-1:0] destM,
   input  logic                      regWrM,
   input  logic                      validM,
   input  logic [`PROC_REG_BITS-1:0] destW,
   input  logic                      regWrW,
   input  logic                      validW,
   output logic                      stall,
   output fwdSel_e                   fwdA,
   output fwdSel_e                   fwdB
);

   logic writesM;
   logic writesW;

   // load data is not ready until the load reaches writeback
   assign stall = validX && memRdX && regWrX && (destX == srcA || destX == srcB);

   assign writesM = validM && regWrM;
   assign writesW = validW && regWrW;

   // the younger producer in X/M takes priority over M/W
   assign fwdA = (writesM && destM == srcAX) ? FWD_XM :
                 (writesW && destW == srcAX) ? FWD_MW : FWD_RF;
   assign fwdB = (writesM && destM == srcBX) ? FWD_XM :
                 (writesW && destW == srcBX) ? FWD_MW : FWD_RF;

endmodule

// ==== execute/execute.sv ====
// operand forwarding, ALU, branch resolution and the execute/memory register
`include "proc_config.svh"

module execute
   import procPkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      validX,
   input  opcode_e                   opX,
   input  aluOp_e                    aluOpX,
   input  wbSrc_e                    wbSrcX,
   input  logic                      memWrX,
   input  logic                      memRdX,
   input  logic [`PROC_REG_BITS-1:0] destX,
   input  logic                      regWrX,
   input  logic [`PROC_WORD-1:0]     opAX,
   input  logic [`PROC_WORD-1:0]     opBX,
   input  logic [`PROC_WORD-1:0]     storeDataX,
   input  logic [`PROC_WORD-1:0]     immX,
   input  logic [`PROC_WORD-1:0]     pcNextX,
   input  logic                      illegalX,
   input  fwdSel_e                   fwdA,
   input  fwdSel_e                   fwdB,
   input  logic [`PROC_WORD-1:0]     fwdDataM,
   input  logic [`PROC_WORD-1:0]     fwdDataW,
   output logic                      redirect,
   output logic [`PROC_WORD-1:0]     redirectPc,
   output logic                      validM,
   output logic [`PROC_WORD-1:0]     aluResM,
   output logic [`PROC_WORD-1:0]     storeDataM,
   output logic [`PROC_REG_BITS-1:0] destM,
   output logic                      regWrM,
   output logic                      memWrM,
   output logic                      memRdM,
   output wbSrc_e                    wbSrcM,
   output logic                      haltM,
   output logic                      illegalM
);

   logic [`PROC_WORD-1:0] aVal;
   logic [`PROC_WORD-1:0] regB;
   logic [`PROC_WORD-1:0] aluB;
   logic [`PROC_WORD-1:0] aluRes;
   logic                  useImm;
   logic                  isZero;

   function automatic logic [`PROC_WORD-1:0] pickOperand(
      input fwdSel_e               sel,
      input logic [`PROC_WORD-1:0] regVal,
      input logic [`PROC_WORD-1:0] xmVal,
      input logic [`PROC_WORD-1:0] mwVal
   );
      case (sel)
         FWD_XM:  return xmVal;
         FWD_MW:  return mwVal;
         default: return regVal;
      endcase
   endfunction

   assign aVal = pickOperand(fwdA, opAX, fwdDataM, fwdDataW);
   assign regB = pickOperand(fwdB, storeDataX, fwdDataM, fwdDataW);

   assign useImm = (opX == OP_ADDI) || (opX == OP_LBI) || (opX == OP_LD) || (opX == OP_ST);
   assign aluB   = useImm ? opBX : regB;

   always_comb begin
      case (aluOpX)
         ALU_SUB: aluRes = aVal - aluB;
         ALU_AND: aluRes = aVal & aluB;
         ALU_XOR: aluRes = aVal ^ aluB;
         ALU_PASSB: aluRes = aluB;
         default: aluRes = aVal + aluB;
      endcase
   end

   // predict not taken, so any taken branch or jump redirects fetch
   assign isZero     = (aVal == '0);
   assign redirect   = validX && ((opX == OP_J) ||
                                  (opX == OP_BEQZ && isZero) ||
                                  (opX == OP_BNEZ && !isZero));
   assign redirectPc = pcNextX + immX;

   always_ff @(posedge clk) begin
      if (rst) begin
         validM <= 1'b0;
      end else begin
         validM <= validX;
      end
   end

   always_ff @(posedge clk) begin
      aluResM    <= aluRes;
      storeDataM <= regB;
      destM      <= destX;
      regWrM     <= regWrX;
      memWrM     <= memWrX;
      memRdM     <= memRdX;
      wbSrcM     <= wbSrcX;
      haltM      <= (opX == OP_HALT);
      illegalM   <= illegalX;
   end

endmodule

// ==== hdl/result.sv ====
// data memory access, memory/writeback register, writeback select
// and the sticky halted and err flags
`include "proc_config.svh"

module result
   import procPkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      validM,
   input  logic [`PROC_WORD-1:0]     aluResM,
   input  logic [`PROC_WORD-1:0]     storeDataM,
   input  logic [`PROC_REG_BITS-1:0] destM,
   input  logic                      regWrM,
   input  logic                      memWrM,
   input  logic                      memRdM,
   input  wbSrc_e                    wbSrcM,
   input  logic                      haltM,
   input  logic                      illegalM,
   output logic [`PROC_WORD-1:0]     dmemAddr,
   output logic [`PROC_WORD-1:0]     dmemWrData,
   output logic                      dmemWr,
   output logic                      dmemRd,
   input  logic [`PROC_WORD-1:0]     dmemRdData,
   output logic                      wbEn,
   output logic [`PROC_REG_BITS-1:0] wbReg,
   output logic [`PROC_WORD-1:0]     wbData,
   output logic                      halted,
   output logic                      err
);

   logic                      validW;
   logic                      regWrW;
   logic                      haltW;
   logic                      illegalW;
   logic [`PROC_REG_BITS-1:0] destW;
   wbSrc_e                    wbSrcW;
   logic [`PROC_WORD-1:0]     aluResW;
   logic [`PROC_WORD-1:0]     memDataW;

   // bubbles never touch memory
   assign dmemAddr   = aluResM;
   assign dmemWrData = storeDataM;
   assign dmemWr     = validM && memWrM;
   assign dmemRd     = validM && memRdM;

   always_ff @(posedge clk) begin
      if (rst) begin
         validW <= 1'b0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         validW <= validM;
         halted <= halted | (validW && haltW);
         err    <= err | (validW && illegalW);
      end
   end

   always_ff @(posedge clk) begin
      regWrW   <= regWrM;
      destW    <= destM;
      wbSrcW   <= wbSrcM;
      aluResW  <= aluResM;
      memDataW <= dmemRdData;
      haltW    <= haltM;
      illegalW <= illegalM;
   end

   assign wbEn   = validW && regWrW;
   assign wbReg  = destW;
   assign wbData = (wbSrcW == WB_MEM) ? memDataW : aluResW;

endmodule

// ==== hdl/proc.sv ====
// five-stage pipelined core with combinational instruction and data ports
`include "proc_config.svh"

module proc
   import procPkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   output logic [`PROC_WORD-1:0] imemAddr,
   input  logic [`PROC_WORD-1:0] imemData,
   output logic [`PROC_WORD-1:0] dmemAddr,
   output logic [`PROC_WORD-1:0] dmemWrData,
   output logic                  dmemWr,
   output logic                  dmemRd,
   input  logic [`PROC_WORD-1:0] dmemRdData,
   output logic                  halted,
   output logic                  err
);

   // fetch/decode
   logic [`PROC_WORD-1:0]     instrD;
   logic [`PROC_WORD-1:0]     pcNextD;
   logic                      validD;
   logic                      haltSeen;
   logic [`PROC_REG_BITS-1:0] srcA;
   logic [`PROC_REG_BITS-1:0] srcB;

   // decode/execute
   logic                      validX;
   opcode_e                   opX;
   aluOp_e                    aluOpX;
   wbSrc_e                    wbSrcX;
   logic                      memWrX;
   logic                      memRdX;
   logic                      regWrX;
   logic                      illegalX;
   logic [`PROC_REG_BITS-1:0] destX;
   logic [`PROC_REG_BITS-1:0] srcAX;
   logic [`PROC_REG_BITS-1:0] srcBX;
   logic [`PROC_WORD-1:0]     opAX;
   logic [`PROC_WORD-1:0]     opBX;
   logic [`PROC_WORD-1:0]     storeDataX;
   logic [`PROC_WORD-1:0]     immX;
   logic [`PROC_WORD-1:0]     pcNextX;

   // hazards and redirect
   logic                      stall;
   fwdSel_e                   fwdA;
   fwdSel_e                   fwdB;
   logic                      redirect;
   logic [`PROC_WORD-1:0]     redirectPc;

   // execute/memory
   logic                      validM;
   logic [`PROC_WORD-1:0]     aluResM;
   logic [`PROC_WORD-1:0]     storeDataM;
   logic [`PROC_REG_BITS-1:0] destM;
   logic                      regWrM;
   logic                      memWrM;
   logic                      memRdM;
   wbSrc_e                    wbSrcM;
   logic                      haltM;
   logic                      illegalM;

   // writeback
   logic                      wbEn;
   logic [`PROC_REG_BITS-1:0] wbReg;
   logic [`PROC_WORD-1:0]     wbData;

   fetch fetch0 (
      .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .haltSeen(haltSeen),
      .redirectPc(redirectPc), .imemAddr(imemAddr), .imemData(imemData),
      .instrD(instrD), .pcNextD(pcNextD), .validD(validD)
   );

   decode decode0 (
      .clk(clk), .rst(rst), .instrD(instrD), .pcNextD(pcNextD), .validD(validD),
      .stall(stall), .flush(redirect), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .srcA(srcA), .srcB(srcB), .haltSeen(haltSeen),
      .validX(validX), .opX(opX), .aluOpX(aluOpX), .wbSrcX(wbSrcX),
      .memWrX(memWrX), .memRdX(memRdX), .destX(destX), .regWrX(regWrX),
      .opAX(opAX), .opBX(opBX), .storeDataX(storeDataX), .immX(immX),
      .pcNextX(pcNextX), .srcAX(srcAX), .srcBX(srcBX), .illegalX(illegalX)
   );

   // wbEn is already qualified by the writeback valid bit
   hazard hazard0 (
      .srcA(srcA), .srcB(srcB), .srcAX(srcAX), .srcBX(srcBX),
      .destX(destX), .regWrX(regWrX), .memRdX(memRdX), .validX(validX),
      .destM(destM), .regWrM(regWrM), .validM(validM),
      .destW(wbReg), .regWrW(wbEn), .validW(wbEn),
      .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
   );

   execute execute0 (
      .clk(clk), .rst(rst), .validX(validX), .opX(opX), .aluOpX(aluOpX),
      .wbSrcX(wbSrcX), .memWrX(memWrX), .memRdX(memRdX), .destX(destX),
      .regWrX(regWrX), .opAX(opAX), .opBX(opBX), .storeDataX(storeDataX),
      .immX(immX), .pcNextX(pcNextX), .illegalX(illegalX),
      .fwdA(fwdA), .fwdB(fwdB), .fwdDataM(aluResM), .fwdDataW(wbData),
      .redirect(redirect), .redirectPc(redirectPc),
      .validM(validM), .aluResM(aluResM), .storeDataM(storeDataM), .destM(destM),
      .regWrM(regWrM), .memWrM(memWrM), .memRdM(memRdM), .wbSrcM(wbSrcM),
      .haltM(haltM), .illegalM(illegalM)
   );

   result result0 (
      .clk(clk), .rst(rst), .validM(validM), .aluResM(aluResM),
      .storeDataM(storeDataM), .destM(destM), .regWrM(regWrM),
      .memWrM(memWrM), .memRdM(memRdM), .wbSrcM(wbSrcM),
      .haltM(haltM), .illegalM(illegalM),
      .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWr(dmemWr),
      .dmemRd(dmemRd), .dmemRdData(dmemRdData),
      .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .halted(halted), .err(err)
   );

endmodule

// ==== test/tbMemory.sv ====
// instruction ROM with both test programs and the data RAM model
`include "proc_config.svh"

module tbMemory
   import procPkg::*;
(
   input  logic                  clk,
   input  logic                  progSel,
   input  logic [`PROC_WORD-1:0] imemAddr,
   output logic [`PROC_WORD-1:0] imemData,
   input  logic [`PROC_WORD-1:0] dmemAddr,
   input  logic [`PROC_WORD-1:0] dmemWrData,
   input  logic                  dmemWr,
   output logic [`PROC_WORD-1:0] dmemRdData
);

   logic [`PROC_WORD-1:0] progOne [64];
   logic [`PROC_WORD-1:0] progTwo [64];
   logic [`PROC_WORD-1:0] ram [256];

   function automatic logic [15:0] rIns(input opcode_e op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] iIns(input opcode_e op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [15:0] lIns(input opcode_e op, input logic [2:0] rd,
                                        input logic [8:0] imm);
      return {op, rd, imm};
   endfunction

   initial begin
      integer     seed;
      logic [8:0] immA;
      logic [8:0] immB;
      seed = 32'h6337_ecef;
      immA = 9'($random(seed));
      immB = 9'($random(seed));
      for (int i = 0; i < 64; i++) begin
         progOne[i] = 16'h0000;
         progTwo[i] = 16'h0000;
      end
      // every RAM word holds its own index and its complement
      for (int i = 0; i < 256; i++) begin
         ram[i] <= {8'(i), ~8'(i)};
      end
      // dependent ALU chain fed by two random constants
      progOne[0]  = lIns(OP_LBI, 3'd1, immA);
      progOne[1]  = lIns(OP_LBI, 3'd2, immB);
      progOne[2]  = rIns(OP_ADD, 3'd3, 3'd1, 3'd2);
      progOne[3]  = rIns(OP_SUB, 3'd4, 3'd3, 3'd1);
      progOne[4]  = iIns(OP_ST, 3'd3, 3'd0, 6'd0);
      progOne[5]  = iIns(OP_ST, 3'd4, 3'd0, 6'd1);
      progOne[6]  = rIns(OP_XOR, 3'd5, 3'd4, 3'd2);
      progOne[7]  = rIns(OP_AND, 3'd6, 3'd5, 3'd3);
      progOne[8]  = iIns(OP_ST, 3'd5, 3'd0, 6'd2);
      progOne[9]  = iIns(OP_ST, 3'd6, 3'd0, 6'd3);
      // load-use on an ALU source, then on store data
      progOne[10] = iIns(OP_LD, 3'd7, 3'd0, 6'd1);
      progOne[11] = iIns(OP_ADDI, 3'd7, 3'd7, 6'd5);
      progOne[12] = iIns(OP_ST, 3'd7, 3'd0, 6'd4);
      progOne[13] = iIns(OP_LD, 3'd5, 3'd0, 6'd20);
      progOne[14] = iIns(OP_ST, 3'd5, 3'd0, 6'd5);
      // three passes, storing the counter at r2
      progOne[15] = lIns(OP_LBI, 3'd1, 9'd3);
      progOne[16] = lIns(OP_LBI, 3'd2, 9'd6);
      progOne[17] = iIns(OP_ST, 3'd1, 3'd2, 6'd0);
      progOne[18] = iIns(OP_ADDI, 3'd2, 3'd2, 6'd1);
      progOne[19] = iIns(OP_ADDI, 3'd1, 3'd1, 6'h3f);
      progOne[20] = lIns(OP_BNEZ, 3'd1, 9'h1fc);
      // taken BEQZ skips two stores
      progOne[21] = lIns(OP_BEQZ, 3'd0, 9'd2);
      progOne[22] = iIns(OP_ST, 3'd1, 3'd0, 6'd30);
      progOne[23] = iIns(OP_ST, 3'd1, 3'd0, 6'd31);
      progOne[24] = iIns(OP_ST, 3'd2, 3'd0, 6'd10);
      progOne[25] = lIns(OP_J, 3'd0, 9'd2);
      progOne[26] = iIns(OP_ST, 3'd0, 3'd0, 6'd11);
      progOne[27] = iIns(OP_ST, 3'd2, 3'd0, 6'd12);
      progOne[28] = rIns(OP_ADD, 3'd0, 3'd3, 3'd4);
      progOne[29] = iIns(OP_ST, 3'd0, 3'd2, 6'd3);
      progOne[30] = lIns(OP_HALT, 3'd0, 9'd0);
      // opcode 13 is undefined
      progTwo[0]  = 16'hD2A5;
      progTwo[1]  = lIns(OP_HALT, 3'd0, 9'd0);
   end

   assign imemData   = progSel ? progTwo[imemAddr[5:0]] : progOne[imemAddr[5:0]];
   assign dmemRdData = ram[dmemAddr[7:0]];

   always @(posedge clk) begin
      if (dmemWr) begin
         ram[dmemAddr[7:0]] <= dmemWrData;
      end
   end

endmodule

// ==== test/procTb.sv ====
// testbench top with clock, reset, reference interpreter,
// store and load checks and watchdog
`include "proc_config.svh"

module procTb
   import procPkg::*;
();

   localparam int MaxSteps = 1000;

   logic                  clk;
   logic                  rst;
   logic                  progSel;
   logic [`PROC_WORD-1:0] imemAddr;
   logic [`PROC_WORD-1:0] imemData;
   logic [`PROC_WORD-1:0] dmemAddr;
   logic [`PROC_WORD-1:0] dmemWrData;
   logic [`PROC_WORD-1:0] dmemRdData;
   logic                  dmemWr;
   logic                  dmemRd;
   logic                  halted;
   logic                  err;

   // expected traffic from the interpreter
   logic [15:0] expStoreAddr [$];
   logic [15:0] expStoreData [$];
   logic [15:0] expLoadAddr [$];
   logic        expErr;
   int          instrCount;

   string testName;
   bit    running;
   bit    haltedSeen;
   bit    errSeen;
   int    storeIdx;
   int    loadIdx;
   time   deadline;

   proc dut0 (
      .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWr(dmemWr),
      .dmemRd(dmemRd), .dmemRdData(dmemRdData), .halted(halted), .err(err)
   );

   tbMemory memory0 (
      .clk(clk), .progSel(progSel), .imemAddr(imemAddr), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWr(dmemWr),
      .dmemRdData(dmemRdData)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic reportMismatch(input string what, input logic [15:0] expected,
                                 input logic [15:0] actual);
      $display("Error in %s, %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic reportProblem(input string msg);
      $display("%s: %s", testName, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // runs the program sequentially, one instruction at a time
   task automatic interpret(input logic sel);
      logic [15:0] modelRegs [8];
      logic [15:0] modelRam [256];
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] ea;
      logic [15:0] imm6;
      logic [15:0] imm9;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      bit          done;
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = 16'h0000;
      end
      for (int i = 0; i < 256; i++) begin
         modelRam[i] = memory0.ram[i];
      end
      expStoreAddr.delete();
      expStoreData.delete();
      expLoadAddr.delete();
      expErr = 1'b0;
      instrCount = 0;
      pc = 16'h0000;
      done = 1'b0;
      while (!done) begin
         if (instrCount >= MaxSteps) begin
            reportProblem("reference model found no HALT within its step limit");
         end
         w = sel ? memory0.progTwo[pc[5:0]] : memory0.progOne[pc[5:0]];
         op = w[15:12];
         rd = w[11:9];
         rs = w[8:6];
         rt = w[5:3];
         imm6 = {{10{w[5]}}, w[5:0]};
         imm9 = {{7{w[8]}}, w[8:0]};
         ea = modelRegs[rs] + imm6;
         pc = pc + 16'd1;
         instrCount++;
         case (op)
            OP_ADD:  modelRegs[rd] = modelRegs[rs] + modelRegs[rt];
            OP_SUB:  modelRegs[rd] = modelRegs[rs] - modelRegs[rt];
            OP_AND:  modelRegs[rd] = modelRegs[rs] & modelRegs[rt];
            OP_XOR:  modelRegs[rd] = modelRegs[rs] ^ modelRegs[rt];
            OP_ADDI: modelRegs[rd] = ea;
            OP_LBI:  modelRegs[rd] = imm9;
            OP_LD: begin
               expLoadAddr.push_back(ea);
               modelRegs[rd] = modelRam[ea[7:0]];
            end
            OP_ST: begin
               expStoreAddr.push_back(ea);
               expStoreData.push_back(modelRegs[rd]);
               modelRam[ea[7:0]] = modelRegs[rd];
            end
            // branch targets count from the next PC
            OP_BEQZ: if (modelRegs[rd] == 16'h0000) pc = pc + imm9;
            OP_BNEZ: if (modelRegs[rd] != 16'h0000) pc = pc + imm9;
            OP_J:    pc = pc + imm9;
            OP_HALT: done = 1'b1;
            OP_NOP:  done = 1'b0;
            default: expErr = 1'b1;
         endcase
      end
   endtask

   task automatic checkResetState();
      assert (imemAddr == 16'h0000) else reportMismatch("reset imemAddr", 16'h0000, imemAddr);
      assert (!dmemWr) else reportMismatch("reset dmemWr", 16'h0000, 16'h0001);
      assert (!dmemRd) else reportMismatch("reset dmemRd", 16'h0000, 16'h0001);
      assert (!halted) else reportMismatch("reset halted", 16'h0000, 16'h0001);
      assert (!err) else reportMismatch("reset err", 16'h0000, 16'h0001);
   endtask

   task automatic runProgram(input logic sel, input string name);
      testName = name;
      @(posedge clk);
      rst <= 1'b1;
      progSel <= sel;
      running = 1'b0;
      interpret(sel);
      storeIdx = 0;
      loadIdx = 0;
      haltedSeen = 1'b0;
      errSeen = 1'b0;
      repeat (4) begin
         @(posedge clk);
         @(negedge clk);
         checkResetState();
      end
      @(posedge clk);
      rst <= 1'b0;
      deadline = $time + time'(8 * (4 * instrCount + 100));
      running = 1'b1;
      @(negedge clk);
      checkResetState();
      while (!halted) @(negedge clk);
      // a quiet tail shows halted holding and no late traffic
      repeat (10) @(negedge clk);
      @(posedge clk);
      running = 1'b0;
      assert (storeIdx == expStoreAddr.size())
         else reportMismatch("store count", 16'(expStoreAddr.size()), 16'(storeIdx));
      assert (loadIdx == expLoadAddr.size())
         else reportMismatch("load count", 16'(expLoadAddr.size()), 16'(loadIdx));
      assert (err == expErr)
         else reportMismatch("final err", {15'h0000, expErr}, {15'h0000, err});
   endtask

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (running) begin
         if (dmemWr) begin
            assert (storeIdx < expStoreAddr.size())
               else reportProblem("a store appeared that the reference model never made");
            assert (dmemAddr == expStoreAddr[storeIdx])
               else reportMismatch("store address", expStoreAddr[storeIdx], dmemAddr);
            assert (dmemWrData == expStoreData[storeIdx])
               else reportMismatch("store data", expStoreData[storeIdx], dmemWrData);
            storeIdx++;
         end
         if (dmemRd) begin
            assert (loadIdx < expLoadAddr.size())
               else reportProblem("a load appeared that the reference model never made");
            assert (dmemAddr == expLoadAddr[loadIdx])
               else reportMismatch("load address", expLoadAddr[loadIdx], dmemAddr);
            loadIdx++;
         end
         if (halted) begin
            if (!haltedSeen) begin
               assert (err == expErr)
                  else reportMismatch("err at halt", {15'h0000, expErr}, {15'h0000, err});
            end
            haltedSeen = 1'b1;
            assert (!dmemWr && !dmemRd)
               else reportProblem("the data port was used after halted rose");
         end else begin
            assert (!haltedSeen) else reportProblem("halted dropped before reset");
         end
         if (err) begin
            errSeen = 1'b1;
         end
         assert (!errSeen || err) else reportProblem("err cleared without a reset");
         assert (expErr || !err) else reportMismatch("err flag", 16'h0000, 16'h0001);
      end
   end

   // watchdog
   always @(posedge clk) begin
      if (running && $time > deadline) begin
         reportProblem("timeout, the core did not halt in the expected time");
      end
   end

   initial begin
      rst = 1'b1;
      progSel = 1'b0;
      running = 1'b0;
      runProgram(1'b0, "program one");
      runProgram(1'b1, "program two");
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+common
common/procPkg.sv
hdl/fetch.sv
decode/regFile.sv
decode/decode.sv
hdl/hazard.sv
execute/execute.sv
hdl/result.sv
hdl/proc.sv
test/tbMemory.sv
test/procTb.sv

// ==== Makefile ====
# Verilator build and run of the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= procTb
BUILD_DIR ?= build
FILELIST  ?= tb.f
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
